// File: sim.f
+incdir+common
+incdir+dv
common/display_pkg.sv
display_buffers/frame_buffer_ram.sv
display_buffers/display_buffers.sv
source/pixel_write_port.sv
source/display_scanout.sv
source/display_subsystem.sv
dv/display_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator and run the display testbench

cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module display_tb --Mdir obj_dir || exit 1
sim_output=$(./obj_dir/Vdisplay_tb)
echo "$sim_output"
echo "$sim_output" | grep -qx "sim passed" && exit 0 || exit 1

// File: dv/display_tb_table.svh
// Display testbench stimulus table
// Columns: operation, register offset, write data, random data flag, expected read value

`ifndef DISPLAY_TB_TABLE_SVH
`define DISPLAY_TB_TABLE_SVH

localparam int num_entries = 28;

localparam entry_t entries [num_entries] = '{
    '{op_read,        `REG_STATUS,        32'h00, 1'b0, 32'h0},
    '{op_check_frame, `REG_STATUS,        32'h00, 1'b0, 32'h0},
    // Back buffer writes across a word boundary, then across the wrap
    '{op_write,       `REG_PIXEL_ADDRESS, 32'h3e, 1'b0, 32'h0},
    '{op_write,       `REG_PIXEL_DATA,    32'h00, 1'b1, 32'h0},
    '{op_write,       `REG_PIXEL_DATA,    32'h00, 1'b1, 32'h0},
    '{op_write,       `REG_PIXEL_DATA,    32'h00, 1'b1, 32'h0},
    '{op_read,        `REG_PIXEL_ADDRESS, 32'h00, 1'b0, 32'h41},
    '{op_write,       `REG_PIXEL_ADDRESS, 32'hfe, 1'b0, 32'h0},
    '{op_write,       `REG_PIXEL_DATA,    32'h00, 1'b1, 32'h0},
    '{op_write,       `REG_PIXEL_DATA,    32'h00, 1'b1, 32'h0},
    '{op_read,        `REG_PIXEL_ADDRESS, 32'h00, 1'b0, 32'h00},
    '{op_check_frame, `REG_STATUS,        32'h00, 1'b0, 32'h0},
    // First swap, pending until the next frame boundary
    '{op_wait_frame,  `REG_STATUS,        32'h00, 1'b0, 32'h0},
    '{op_write,       `REG_CONTROL,       32'h01, 1'b0, 32'h0},
    '{op_read,        `REG_STATUS,        32'h00, 1'b0, 32'h1},
    '{op_wait_frame,  `REG_STATUS,        32'h00, 1'b0, 32'h0},
    '{op_read,        `REG_STATUS,        32'h00, 1'b0, 32'h2},
    '{op_check_frame, `REG_STATUS,        32'h00, 1'b0, 32'h0},
    // Buffer A is now the back buffer
    '{op_write,       `REG_PIXEL_ADDRESS, 32'h10, 1'b0, 32'h0},
    '{op_write,       `REG_PIXEL_DATA,    32'h00, 1'b1, 32'h0},
    '{op_write,       `REG_PIXEL_DATA,    32'h00, 1'b1, 32'h0},
    '{op_wait_frame,  `REG_STATUS,        32'h00, 1'b0, 32'h0},
    '{op_write,       `REG_CONTROL,       32'h01, 1'b0, 32'h0},
    '{op_wait_frame,  `REG_STATUS,        32'h00, 1'b0, 32'h0},
    '{op_read,        `REG_STATUS,        32'h00, 1'b0, 32'h0},
    '{op_write,       `REG_PIXEL_ADDRESS, 32'h3f, 1'b0, 32'h0},
    '{op_write,       `REG_PIXEL_DATA,    32'h00, 1'b1, 32'h0},
    '{op_check_frame, `REG_STATUS,        32'h00, 1'b0, 32'h0}
};

`endif

// File: dv/display_tb.sv
// Display subsystem testbench
// Applies Wishbone traffic from a stimulus table and compares the scan-out
// stream with a two-buffer reference model

`timescale 1ns/100ps

`include "display_defs.svh"

module display_tb;

    import display_pkg::*;

    localparam logic [1:0] op_write       = 2'd0;
    localparam logic [1:0] op_read        = 2'd1;
    localparam logic [1:0] op_wait_frame  = 2'd2;
    localparam logic [1:0] op_check_frame = 2'd3;

    typedef struct packed {
        logic [1:0]  op;
        logic [1:0]  offset;
        logic [31:0] data;
        logic        random;
        logic [31:0] expected;
    } entry_t;

    `include "display_tb_table.svh"

    localparam int frame_pixels   = `DISPLAY_WIDTH * `DISPLAY_HEIGHT;
    localparam int timeout_cycles = num_entries * 2 * frame_pixels + 100;

    logic        clock_in;
    logic        reset_n_in;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [1:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    pixel_t      pixel_out;
    logic        pixel_valid;
    logic        frame_start;

    // Reference model of both buffers
    pixel_t      model_a [frame_pixels];
    pixel_t      model_b [frame_pixels];
    logic        model_front_b;
    logic        model_pending;
    logic [7:0]  model_address;

    int          entry_errors;
    int          pass_count;
    int          fail_count;
    int          cycle_count;

    display_subsystem u_dut (
        .clock_in    (clock_in),
        .reset_n_in  (reset_n_in),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .pixel_out   (pixel_out),
        .pixel_valid (pixel_valid),
        .frame_start (frame_start)
    );

    initial begin
        clock_in = 1'b0;
        forever #4 clock_in = ~clock_in;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clock_in);
            cycle_count++;
        end
        $display("Timeout: the table did not finish within %0d cycles", timeout_cycles);
        $display("sim failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
            entry_errors++;
        end
    endtask

    // Classic cycle, held through the ack cycle so a write commits
    task automatic bus_access(input logic write, input logic [1:0] offset,
                              input logic [31:0] data, output logic [31:0] read_data);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = write;
        wb_adr   = offset;
        wb_dat_w = data;
        do begin
            @(negedge clock_in);
        end while (wb_ack !== 1'b1);
        read_data = wb_dat_r;
        @(negedge clock_in);
        // Acknowledge lasts a single cycle
        check_value("wb_ack", 32'd0, 32'(wb_ack));
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic update_model(input logic [1:0] offset, input logic [31:0] data);
        if (offset == `REG_PIXEL_ADDRESS) begin
            model_address = data[7:0];
        end else if (offset == `REG_PIXEL_DATA) begin
            // Writes go to the buffer that is off screen
            if (model_front_b) begin
                model_a[model_address] = data[3:0];
            end else begin
                model_b[model_address] = data[3:0];
            end
            model_address = model_address + 8'd1;
        end else if (offset == `REG_CONTROL && data[0]) begin
            model_pending = 1'b1;
        end
    endtask

    // A pending swap shows up from this frame on
    task automatic wait_frame_start();
        do begin
            @(negedge clock_in);
        end while (frame_start !== 1'b1);
        if (model_pending) begin
            model_front_b = !model_front_b;
            model_pending = 1'b0;
        end
    endtask

    task automatic check_frame();
        pixel_t expected;
        wait_frame_start();
        for (int i = 0; i < frame_pixels; i++) begin
            expected = model_front_b ? model_b[i] : model_a[i];
            check_value($sformatf("pixel_out[%0d]", i), 32'(expected), 32'(pixel_out));
            check_value("pixel_valid", 32'd1, 32'(pixel_valid));
            if (i > 0) begin
                check_value("frame_start", 32'd0, 32'(frame_start));
            end
            if (i < frame_pixels - 1) begin
                @(negedge clock_in);
            end
        end
    endtask

    task automatic apply_entry(input entry_t entry);
        logic [31:0] data;
        logic [31:0] read_data;
        data = entry.random ? $urandom : entry.data;
        case (entry.op)
            op_write: begin
                bus_access(1'b1, entry.offset, data, read_data);
                update_model(entry.offset, data);
            end
            op_read: begin
                bus_access(1'b0, entry.offset, 32'd0, read_data);
                check_value("wb_dat_r", entry.expected, read_data);
            end
            op_wait_frame: begin
                wait_frame_start();
            end
            default: begin
                check_frame();
            end
        endcase
    endtask

    initial begin
        void'($urandom(5633));
        reset_n_in    = 1'b0;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = 2'd0;
        wb_dat_w      = 32'd0;
        model_front_b = 1'b0;
        model_pending = 1'b0;
        model_address = 8'd0;
        pass_count    = 0;
        fail_count    = 0;
        for (int i = 0; i < frame_pixels; i++) begin
            model_a[i] = '0;
            model_b[i] = '0;
        end
        repeat (4) @(negedge clock_in);
        reset_n_in = 1'b1;

        for (int n = 0; n < num_entries; n++) begin
            entry_errors = 0;
            apply_entry(entries[n]);
            if (entry_errors == 0) begin
                pass_count++;
                $display("Entry %0d (op %0d) ok", n, entries[n].op);
            end else begin
                fail_count++;
                $display("Entry %0d (op %0d) failed, %0d mismatches", n, entries[n].op,
                         entry_errors);
            end
        end

        $display("Entries passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: source/display_subsystem.sv
// Display subsystem top level
// Wishbone write port, raster scan-out and double-buffered frame store

`timescale 1ns/100ps

`include "display_defs.svh"

module display_subsystem (
    input  logic                  clock_in,
    input  logic                  reset_n_in,

    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [1:0]            wb_adr,
    input  logic [31:0]           wb_dat_w,
    output logic [31:0]           wb_dat_r,
    output logic                  wb_ack,

    output display_pkg::pixel_t   pixel_out,
    output logic                  pixel_valid,
    output logic                  frame_start
);

    import display_pkg::*;

    logic                             pixel_write_enable;
    logic [`PIXEL_ADDRESS_BITS-1:0]   pixel_write_address;
    pixel_t                           pixel_write_data;
    logic                             swap_request;
    logic                             swap_pending;
    buffer_select_t                   front_buffer;
    logic [`PIXEL_ADDRESS_BITS-1:0]   scan_address;
    logic                             scan_frame_start;

    pixel_write_port u_pixel_write_port (
        .clock_in            (clock_in),
        .reset_n_in          (reset_n_in),
        .wb_cyc              (wb_cyc),
        .wb_stb              (wb_stb),
        .wb_we               (wb_we),
        .wb_adr              (wb_adr),
        .wb_dat_w            (wb_dat_w),
        .wb_dat_r            (wb_dat_r),
        .wb_ack              (wb_ack),
        .swap_pending        (swap_pending),
        .front_buffer        (front_buffer),
        .pixel_write_enable  (pixel_write_enable),
        .pixel_write_address (pixel_write_address),
        .pixel_write_data    (pixel_write_data),
        .swap_request        (swap_request)
    );

    display_scanout u_display_scanout (
        .clock_in            (clock_in),
        .reset_n_in          (reset_n_in),
        .scan_address        (scan_address),
        .scan_frame_start    (scan_frame_start)
    );

    display_buffers u_display_buffers (
        .clock_in            (clock_in),
        .reset_n_in          (reset_n_in),
        .pixel_write_enable  (pixel_write_enable),
        .pixel_write_address (pixel_write_address),
        .pixel_write_data    (pixel_write_data),
        .swap_request        (swap_request),
        .scan_address        (scan_address),
        .scan_frame_start    (scan_frame_start),
        .swap_pending        (swap_pending),
        .front_buffer        (front_buffer),
        .pixel_out           (pixel_out),
        .pixel_valid         (pixel_valid),
        .frame_start         (frame_start)
    );

endmodule

// File: source/display_scanout.sv
// Raster scan-out counter
// Walks column and line every clock and forms the linear pixel read address

`timescale 1ns/100ps

`include "display_defs.svh"

module display_scanout (
    input  logic                              clock_in,
    input  logic                              reset_n_in,
    output logic [`PIXEL_ADDRESS_BITS-1:0]    scan_address,
    output logic                              scan_frame_start
);

    localparam int column_bits = $clog2(`DISPLAY_WIDTH);
    localparam int line_bits   = $clog2(`DISPLAY_HEIGHT);

    logic [column_bits-1:0] column;
    logic [line_bits-1:0]   line;

    always_ff @(posedge clock_in) begin
        if (reset_n_in == 0) begin
            column <= '0;
            line   <= '0;
        end else begin
            if (column == column_bits'(`DISPLAY_WIDTH - 1)) begin
                column <= '0;

                // Last line wraps back to the top of the frame
                if (line == line_bits'(`DISPLAY_HEIGHT - 1)) begin
                    line <= '0;
                end else begin
                    line <= line + 1'b1;
                end
            end else begin
                column <= column + 1'b1;
            end
        end
    end

    assign scan_address     = {line, column};
    assign scan_frame_start = (line == '0) && (column == '0);

endmodule

// File: source/pixel_write_port.sv
// Wishbone classic slave for the frame store
// Pixel address, pixel data, control and status registers

`timescale 1ns/100ps

`include "display_defs.svh"

module pixel_write_port (
    input  logic                              clock_in,
    input  logic                              reset_n_in,

    input  logic                              wb_cyc,
    input  logic                              wb_stb,
    input  logic                              wb_we,
    input  logic [1:0]                        wb_adr,
    input  logic [31:0]                       wb_dat_w,
    output logic [31:0]                       wb_dat_r,
    output logic                              wb_ack,

    input  logic                              swap_pending,
    input  display_pkg::buffer_select_t       front_buffer,

    output logic                              pixel_write_enable,
    output logic [`PIXEL_ADDRESS_BITS-1:0]    pixel_write_address,
    output display_pkg::pixel_t               pixel_write_data,
    output logic                              swap_request
);

    import display_pkg::*;

    logic [`PIXEL_ADDRESS_BITS-1:0] pixel_address;
    logic                           bus_write;

    // Writes take effect at the end of the acknowledge cycle
    assign bus_write = wb_ack && wb_cyc && wb_stb && wb_we;

    always_ff @(posedge clock_in) begin
        if (reset_n_in == 0) begin
            wb_ack             <= 1'b0;
            pixel_address      <= '0;
            pixel_write_enable <= 1'b0;
            swap_request       <= 1'b0;
        end else begin
            // Single-cycle ack, no wait states
            wb_ack <= wb_cyc && wb_stb && !wb_ack;

            pixel_write_enable <= bus_write && (wb_adr == `REG_PIXEL_DATA);
            swap_request       <= bus_write && (wb_adr == `REG_CONTROL) && wb_dat_w[0];

            if (bus_write && wb_adr == `REG_PIXEL_ADDRESS) begin
                pixel_address <= wb_dat_w[`PIXEL_ADDRESS_BITS-1:0];
            end else if (bus_write && wb_adr == `REG_PIXEL_DATA) begin
                // Wraps at the end of the frame
                pixel_address <= pixel_address + 1'b1;
            end
        end
    end

    // Pixel payload captured with the strobe
    always_ff @(posedge clock_in) begin
        if (bus_write && wb_adr == `REG_PIXEL_DATA) begin
            pixel_write_address <= pixel_address;
            pixel_write_data    <= wb_dat_w[`PIXEL_BITS-1:0];
        end
    end

    // Read data is presented during the ack cycle
    always_comb begin
        case (wb_adr)
            `REG_PIXEL_ADDRESS: begin
                wb_dat_r = {{(32 - `PIXEL_ADDRESS_BITS){1'b0}}, pixel_address};
            end
            `REG_STATUS: begin
                wb_dat_r = {30'd0, front_buffer == BUFFER_B, swap_pending};
            end
            default: begin
                wb_dat_r = '0;
            end
        endcase
    end

endmodule

// File: display_buffers/display_buffers.sv
// Double-buffered frame store
// Writes go to the back buffer, scan-out reads the front buffer, and a
// requested swap waits for the scan to return to pixel address zero

`timescale 1ns/100ps

`include "display_defs.svh"

module display_buffers (
    input  logic                              clock_in,
    input  logic                              reset_n_in,

    input  logic                              pixel_write_enable,
    input  logic [`PIXEL_ADDRESS_BITS-1:0]    pixel_write_address,
    input  display_pkg::pixel_t               pixel_write_data,
    input  logic                              swap_request,

    input  logic [`PIXEL_ADDRESS_BITS-1:0]    scan_address,
    input  logic                              scan_frame_start,

    output logic                              swap_pending,
    output display_pkg::buffer_select_t       front_buffer,

    output display_pkg::pixel_t               pixel_out,
    output logic                              pixel_valid,
    output logic                              frame_start
);

    import display_pkg::*;

    localparam int pixel_index_bits = `PIXEL_ADDRESS_BITS - `WORD_ADDRESS_BITS;

    logic                               write_enable_q;
    logic [`PIXEL_ADDRESS_BITS-1:0]     write_address_q;
    pixel_t                             write_data_q;

    logic [`PIXELS_PER_WORD-1:0]        nibble_enable;
    logic [`PIXELS_PER_WORD-1:0]        nibble_enable_a;
    logic [`PIXELS_PER_WORD-1:0]        nibble_enable_b;
    pixel_word_t                        write_word;

    logic                               swap_now;
    buffer_select_t                     read_buffer;
    buffer_select_t                     read_buffer_q;
    logic [`WORD_ADDRESS_BITS-1:0]      read_address_a;
    logic [`WORD_ADDRESS_BITS-1:0]      read_address_b;
    logic [pixel_index_bits-1:0]        pixel_index_q;
    pixel_word_t                        read_word_a;
    pixel_word_t                        read_word_b;
    pixel_word_t                        read_word_front;

    logic                               frame_start_q;
    logic                               pixel_valid_q;

    // Swap happens on the address-0 cycle, so that read already uses the new buffer
    assign swap_now    = swap_pending && scan_frame_start;
    assign read_buffer = swap_now ? buffer_select_t'(~front_buffer) : front_buffer;

    always_ff @(posedge clock_in) begin
        if (reset_n_in == 0) begin
            swap_pending   <= 1'b0;
            front_buffer   <= BUFFER_A;
            write_enable_q <= 1'b0;
            frame_start_q  <= 1'b0;
            frame_start    <= 1'b0;
            pixel_valid_q  <= 1'b0;
            pixel_valid    <= 1'b0;
        end else begin
            if (swap_now) begin
                front_buffer <= buffer_select_t'(~front_buffer);
                swap_pending <= swap_request;
            end else if (swap_request) begin
                swap_pending <= 1'b1;
            end

            write_enable_q <= pixel_write_enable;

            // Markers follow the two-stage read pipeline
            frame_start_q <= scan_frame_start;
            frame_start   <= frame_start_q;
            pixel_valid_q <= 1'b1;
            pixel_valid   <= pixel_valid_q;
        end
    end

    // Write payload and read pipeline
    always_ff @(posedge clock_in) begin
        write_address_q <= pixel_write_address;
        write_data_q    <= pixel_write_data;

        read_buffer_q <= read_buffer;
        pixel_index_q <= scan_address[pixel_index_bits-1:0];
        pixel_out     <= read_word_front.pixels[pixel_index_q];
    end

    // One nibble lane per pixel in the word
    always_comb begin
        for (int i = 0; i < `PIXELS_PER_WORD; i++) begin
            nibble_enable[i] = write_enable_q &&
                               (write_address_q[pixel_index_bits-1:0] == i);
        end
    end

    assign write_word.pixels = {`PIXELS_PER_WORD{write_data_q}};

    // Writes land in whichever buffer is not on screen
    assign nibble_enable_a = (front_buffer == BUFFER_B) ? nibble_enable : '0;
    assign nibble_enable_b = (front_buffer == BUFFER_A) ? nibble_enable : '0;

    assign read_address_a = (read_buffer == BUFFER_A) ?
                            scan_address[`PIXEL_ADDRESS_BITS-1:pixel_index_bits] : '0;
    assign read_address_b = (read_buffer == BUFFER_B) ?
                            scan_address[`PIXEL_ADDRESS_BITS-1:pixel_index_bits] : '0;

    assign read_word_front = (read_buffer_q == BUFFER_A) ? read_word_a : read_word_b;

    frame_buffer_ram u_buffer_a (
        .clock_in            (clock_in),
        .write_address       (write_address_q[`PIXEL_ADDRESS_BITS-1:pixel_index_bits]),
        .write_nibble_enable (nibble_enable_a),
        .write_word          (write_word),
        .read_address        (read_address_a),
        .read_word           (read_word_a)
    );

    frame_buffer_ram u_buffer_b (
        .clock_in            (clock_in),
        .write_address       (write_address_q[`PIXEL_ADDRESS_BITS-1:pixel_index_bits]),
        .write_nibble_enable (nibble_enable_b),
        .write_word          (write_word),
        .read_address        (read_address_b),
        .read_word           (read_word_b)
    );

endmodule

// File: display_buffers/frame_buffer_ram.sv
// Frame buffer RAM
// 32-word simple dual-port memory with a write enable per nibble
// and a registered read port

`timescale 1ns/100ps

`include "display_defs.svh"

module frame_buffer_ram (
    input  logic                              clock_in,
    input  logic [`WORD_ADDRESS_BITS-1:0]     write_address,
    input  logic [`PIXELS_PER_WORD-1:0]       write_nibble_enable,
    input  display_pkg::pixel_word_t          write_word,
    input  logic [`WORD_ADDRESS_BITS-1:0]     read_address,
    output display_pkg::pixel_word_t          read_word
);

    import display_pkg::*;

    pixel_word_t memory [2**`WORD_ADDRESS_BITS];

    // Blank frame at power up
    initial begin
        for (int i = 0; i < 2**`WORD_ADDRESS_BITS; i++) begin
            memory[i] = '0;
        end
    end

    always_ff @(posedge clock_in) begin
        for (int i = 0; i < `PIXELS_PER_WORD; i++) begin
            if (write_nibble_enable[i]) begin
                memory[write_address].pixels[i] <= write_word.pixels[i];
            end
        end

        read_word.raw <= memory[read_address].raw;
    end

endmodule

// File: common/display_pkg.sv
// Display frame store types
// Pixel value, packed pixel word with raw and per-pixel views, front buffer select

`include "display_defs.svh"

package display_pkg;

    // One pixel of the panel
    typedef logic [`PIXEL_BITS-1:0] pixel_t;

    // A RAM word, seen either as the stored word or as eight pixels
    // Pixel 0 sits in the lowest nibble
    typedef union packed {
        logic [`PIXEL_BITS*`PIXELS_PER_WORD-1:0] raw;
        pixel_t [`PIXELS_PER_WORD-1:0]           pixels;
    } pixel_word_t;

    // Names the buffer currently being scanned out
    typedef enum logic {
        BUFFER_A = 1'b0,
        BUFFER_B = 1'b1
    } buffer_select_t;

endpackage

// File: common/display_defs.svh
// Display frame store constants
// Frame geometry, pixel packing, address widths and Wishbone register offsets

`ifndef DISPLAY_DEFS_SVH
`define DISPLAY_DEFS_SVH

// Frame geometry
`define DISPLAY_WIDTH           32
`define DISPLAY_HEIGHT          8

// Pixel packing into 32-bit RAM words
`define PIXEL_BITS              4
`define PIXELS_PER_WORD         8

// Linear pixel address and RAM word address widths
`define PIXEL_ADDRESS_BITS      8
`define WORD_ADDRESS_BITS       5

// Wishbone word offsets
`define REG_PIXEL_ADDRESS       2'd0
`define REG_PIXEL_DATA          2'd1
`define REG_CONTROL             2'd2
`define REG_STATUS              2'd3

`endif
